// ==== design/trace_pkg.sv ====
// commit trace shared definitions

package trace_pkg;

  // ----------------------------------------
  // widths and words
  // ----------------------------------------
  localparam int unsigned PcWidth = 64;

  typedef logic [PcWidth-1:0] pc_t;

  // mcause layout, top bit flags an interrupt
  typedef logic [63:0] cause_t;

  localparam int unsigned CauseIrqBit = 63;

  typedef logic [63:0] counter_t;

  // ----------------------------------------
  // performance counter map
  // ----------------------------------------
  typedef logic [1:0] perf_addr_t;

  // instructions retired without exception
  localparam perf_addr_t PerfInstret   = 2'd0;
  // synchronous exceptions
  localparam perf_addr_t PerfException = 2'd1;
  localparam perf_addr_t PerfInterrupt = 2'd2;
  // pcs lost on a full queue
  localparam perf_addr_t PerfDropped   = 2'd3;

endpackage

// ==== design/commit_if.sv ====
// commit port bundle

`timescale 1ns/1ps

interface commit_if #(
  parameter int unsigned NrCommitPorts = 2
);

  // one lane per commit port
  logic [NrCommitPorts-1:0]                  ack;
  trace_pkg::pc_t [NrCommitPorts-1:0]        pc;
  logic [NrCommitPorts-1:0]                  ex_valid;
  trace_pkg::cause_t [NrCommitPorts-1:0]     cause;

  // commit side drives the bundle
  modport src (
    output ack,
    output pc,
    output ex_valid,
    output cause
  );

  // queues and counters only watch
  modport mon (
    input ack,
    input pc,
    input ex_valid,
    input cause
  );

endinterface

// ==== design/pc_queue_bank.sv ====
// per-port pc queues

`timescale 1ns/1ps

module pc_queue_bank #(
  parameter int unsigned NrCommitPorts = 2,
  parameter int unsigned QueueDepth    = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  commit_if.mon                              commit,
  input  logic [NrCommitPorts-1:0]           pop_i,
  output trace_pkg::pc_t [NrCommitPorts-1:0] head_pc_o,
  output logic [NrCommitPorts-1:0]           nonempty_o,
  output logic [NrCommitPorts-1:0]           drop_o
);

  localparam int unsigned PtrWidth   = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CountWidth = $clog2(QueueDepth + 1);

  // ring pointer step with explicit wrap
  function automatic logic [PtrWidth-1:0] ptr_inc(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(QueueDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  for (genvar p = 0; p < NrCommitPorts; p++) begin : gen_queue
    trace_pkg::pc_t          mem_q [QueueDepth];
    logic [PtrWidth-1:0]     wr_ptr_q;
    logic [PtrWidth-1:0]     rd_ptr_q;
    logic [CountWidth-1:0]   count_q;
    logic                    retire;
    logic                    full;
    logic                    push;

    // only clean retires are traced
    assign retire = commit.ack[p] & ~commit.ex_valid[p];
    assign full   = (count_q == CountWidth'(QueueDepth));

    // a pop in the same cycle frees the slot we write into
    assign push      = retire & (~full | pop_i[p]);
    assign drop_o[p] = retire & full & ~pop_i[p];

    assign head_pc_o[p]  = mem_q[rd_ptr_q];
    assign nonempty_o[p] = (count_q != '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (push) begin
          wr_ptr_q <= ptr_inc(wr_ptr_q);
        end
        if (pop_i[p]) begin
          rd_ptr_q <= ptr_inc(rd_ptr_q);
        end
        unique case ({push, pop_i[p]})
          2'b10:   count_q <= count_q + 1'b1;
          2'b01:   count_q <= count_q - 1'b1;
          default: count_q <= count_q;
        endcase
      end
    end

    // storage
    always_ff @(posedge clk_i) begin
      if (push) begin
        mem_q[wr_ptr_q] <= commit.pc[p];
      end
    end
  end

endmodule

// ==== design/trace_arbiter.sv ====
// round-robin trace merge

`timescale 1ns/1ps

module trace_arbiter #(
  parameter int unsigned NrCommitPorts = 2,
  parameter int unsigned TraceCredits  = 2,
  localparam int unsigned PortIdxWidth = (NrCommitPorts > 1) ? $clog2(NrCommitPorts) : 1
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  trace_pkg::pc_t [NrCommitPorts-1:0] head_pc_i,
  input  logic [NrCommitPorts-1:0]           nonempty_i,
  output logic [NrCommitPorts-1:0]           pop_o,
  input  logic                               trace_credit_i,
  output logic                               trace_valid_o,
  output trace_pkg::pc_t                     trace_pc_o,
  output logic [PortIdxWidth-1:0]            trace_port_o
);

  localparam int unsigned CreditWidth = $clog2(TraceCredits + 1);

  logic [PortIdxWidth-1:0] rr_q;
  logic [PortIdxWidth-1:0] rr_d;
  logic [CreditWidth-1:0]  credit_q;
  logic [CreditWidth-1:0]  credit_d;
  logic                    grant;
  logic [PortIdxWidth-1:0] grant_idx;

  logic                    valid_q;
  trace_pkg::pc_t          pc_q;
  logic [PortIdxWidth-1:0] port_q;

  // port index off steps past base, modulo port count
  function automatic logic [PortIdxWidth-1:0] port_at(
    input logic [PortIdxWidth-1:0] base,
    input int unsigned             off
  );
    int unsigned idx;
    idx = base;
    idx = (idx + off) % NrCommitPorts;
    return PortIdxWidth'(idx);
  endfunction

  // ----------------------------------------
  // grant selection
  // ----------------------------------------
  always_comb begin
    grant     = 1'b0;
    grant_idx = rr_q;
    if (credit_q != '0) begin
      // first nonempty queue at or after the pointer
      for (int unsigned off = 0; off < NrCommitPorts; off++) begin
        if (!grant && nonempty_i[port_at(rr_q, off)]) begin
          grant     = 1'b1;
          grant_idx = port_at(rr_q, off);
        end
      end
    end
  end

  for (genvar p = 0; p < NrCommitPorts; p++) begin : gen_pop
    assign pop_o[p] = grant & (grant_idx == PortIdxWidth'(p));
  end

  assign rr_d = grant ? port_at(grant_idx, 1) : rr_q;

  // spend and return in one cycle cancel
  always_comb begin
    unique case ({grant, trace_credit_i})
      2'b10:   credit_d = credit_q - 1'b1;
      2'b01:   credit_d = credit_q + 1'b1;
      default: credit_d = credit_q;
    endcase
  end

  // ----------------------------------------
  // state and output register
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q     <= '0;
      credit_q <= CreditWidth'(TraceCredits);
      valid_q  <= 1'b0;
    end else begin
      rr_q     <= rr_d;
      credit_q <= credit_d;
      valid_q  <= grant;
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      pc_q   <= head_pc_i[grant_idx];
      port_q <= grant_idx;
    end
  end

  assign trace_valid_o = valid_q;
  assign trace_pc_o    = pc_q;
  assign trace_port_o  = port_q;

endmodule

// ==== design/perf_counters.sv ====
// commit event counters

`timescale 1ns/1ps

module perf_counters #(
  parameter int unsigned NrCommitPorts = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  commit_if.mon                    commit,
  input  logic [NrCommitPorts-1:0] drop_i,
  input  trace_pkg::perf_addr_t    addr_i,
  output trace_pkg::counter_t      data_o
);

  localparam int unsigned NrCounters = 2 ** $bits(trace_pkg::perf_addr_t);
  localparam int unsigned IncWidth   = $clog2(NrCommitPorts + 1);

  trace_pkg::counter_t   cnt_q [NrCounters];
  logic [IncWidth-1:0]   inc   [NrCounters];

  // ----------------------------------------
  // per-cycle event totals
  // ----------------------------------------
  always_comb begin
    for (int unsigned k = 0; k < NrCounters; k++) begin
      inc[k] = '0;
    end
    for (int unsigned p = 0; p < NrCommitPorts; p++) begin
      if (commit.ack[p]) begin
        if (!commit.ex_valid[p]) begin
          inc[trace_pkg::PerfInstret] = inc[trace_pkg::PerfInstret] + 1'b1;
        end else if (commit.cause[p][trace_pkg::CauseIrqBit]) begin
          inc[trace_pkg::PerfInterrupt] = inc[trace_pkg::PerfInterrupt] + 1'b1;
        end else begin
          inc[trace_pkg::PerfException] = inc[trace_pkg::PerfException] + 1'b1;
        end
      end
      // drops come from the queue bank, already qualified
      if (drop_i[p]) begin
        inc[trace_pkg::PerfDropped] = inc[trace_pkg::PerfDropped] + 1'b1;
      end
    end
  end

  // ----------------------------------------
  // counters
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned k = 0; k < NrCounters; k++) begin
        cnt_q[k] <= '0;
      end
    end else begin
      for (int unsigned k = 0; k < NrCounters; k++) begin
        cnt_q[k] <= cnt_q[k] + trace_pkg::counter_t'(inc[k]);
      end
    end
  end

  // read port, same cycle
  assign data_o = cnt_q[addr_i];

endmodule

// ==== design/commit_trace_top.sv ====
// commit trace and counters top level

`timescale 1ns/1ps

module commit_trace_top #(
  parameter int unsigned NrCommitPorts = 2,
  parameter int unsigned QueueDepth    = 4,
  parameter int unsigned TraceCredits  = 2,
  localparam int unsigned PortIdxWidth = (NrCommitPorts > 1) ? $clog2(NrCommitPorts) : 1
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // commit ports
  input  logic [NrCommitPorts-1:0]              commit_ack_i,
  input  trace_pkg::pc_t [NrCommitPorts-1:0]    commit_pc_i,
  input  logic [NrCommitPorts-1:0]              commit_ex_valid_i,
  input  trace_pkg::cause_t [NrCommitPorts-1:0] commit_cause_i,
  // credited trace stream
  output logic                                  trace_valid_o,
  output trace_pkg::pc_t                        trace_pc_o,
  output logic [PortIdxWidth-1:0]               trace_port_o,
  input  logic                                  trace_credit_i,
  // counter read
  input  trace_pkg::perf_addr_t                 perf_addr_i,
  output trace_pkg::counter_t                   perf_data_o
);

  // ----------------------------------------
  // commit bundle
  // ----------------------------------------
  commit_if #(
    .NrCommitPorts ( NrCommitPorts )
  ) commit_bus ();

  assign commit_bus.ack      = commit_ack_i;
  assign commit_bus.pc       = commit_pc_i;
  assign commit_bus.ex_valid = commit_ex_valid_i;
  assign commit_bus.cause    = commit_cause_i;

  // queue <-> arbiter
  trace_pkg::pc_t [NrCommitPorts-1:0] head_pc;
  logic [NrCommitPorts-1:0]           nonempty;
  logic [NrCommitPorts-1:0]           pop;
  // queue -> counters
  logic [NrCommitPorts-1:0]           drop;

  // ----------------------------------------
  // pc queues
  // ----------------------------------------
  pc_queue_bank #(
    .NrCommitPorts ( NrCommitPorts ),
    .QueueDepth    ( QueueDepth    )
  ) i_pc_queue_bank (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .commit     ( commit_bus ),
    .pop_i      ( pop        ),
    .head_pc_o  ( head_pc    ),
    .nonempty_o ( nonempty   ),
    .drop_o     ( drop       )
  );

  // ----------------------------------------
  // trace merge
  // ----------------------------------------
  trace_arbiter #(
    .NrCommitPorts ( NrCommitPorts ),
    .TraceCredits  ( TraceCredits  )
  ) i_trace_arbiter (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .head_pc_i      ( head_pc        ),
    .nonempty_i     ( nonempty       ),
    .pop_o          ( pop            ),
    .trace_credit_i ( trace_credit_i ),
    .trace_valid_o  ( trace_valid_o  ),
    .trace_pc_o     ( trace_pc_o     ),
    .trace_port_o   ( trace_port_o   )
  );

  // ----------------------------------------
  // event counters
  // ----------------------------------------
  perf_counters #(
    .NrCommitPorts ( NrCommitPorts )
  ) i_perf_counters (
    .clk_i  ( clk_i       ),
    .rst_ni ( rst_ni      ),
    .commit ( commit_bus  ),
    .drop_i ( drop        ),
    .addr_i ( perf_addr_i ),
    .data_o ( perf_data_o )
  );

endmodule

// ==== tests/tb_checker.sv ====
// commit trace checker

`timescale 1ns/1ps

module tb_checker #(
  parameter int unsigned NrCommitPorts = 2,
  parameter int unsigned QueueDepth    = 4,
  parameter int unsigned TraceCredits  = 2,
  localparam int unsigned PortIdxWidth = (NrCommitPorts > 1) ? $clog2(NrCommitPorts) : 1
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic [NrCommitPorts-1:0]              commit_ack_i,
  input  trace_pkg::pc_t [NrCommitPorts-1:0]    commit_pc_i,
  input  logic [NrCommitPorts-1:0]              commit_ex_valid_i,
  input  trace_pkg::cause_t [NrCommitPorts-1:0] commit_cause_i,
  input  logic                                  trace_valid_i,
  input  trace_pkg::pc_t                        trace_pc_i,
  input  logic [PortIdxWidth-1:0]               trace_port_i,
  input  logic                                  trace_credit_i,
  output trace_pkg::perf_addr_t                 perf_addr_o,
  input  trace_pkg::counter_t                   perf_data_i,
  input  string                                 test_name_i,
  input  logic                                  check_req_i,
  output logic                                  check_done_o,
  input  logic                                  run_done_i,
  output logic                                  summary_done_o,
  input  int unsigned                           cycle_limit_i,
  output logic                                  timeout_o,
  output int unsigned                           errors_o
);

  // reference model state, mirrors the dut during the current cycle
  trace_pkg::pc_t        ref_mem [NrCommitPorts][QueueDepth];
  int unsigned           ref_fill [NrCommitPorts];
  trace_pkg::counter_t   ref_cnt [4];
  int unsigned           credits;
  int unsigned           rr;
  logic                  exp_valid;
  trace_pkg::pc_t        exp_pc;
  int unsigned           exp_port;

  int unsigned           items_seen;
  int unsigned           credits_seen;
  int unsigned           n_errors = 0;
  int unsigned           n_checks = 0;
  int unsigned           n_tests = 0;
  int unsigned           test_err_base = 0;
  int unsigned           reads_done = 0;
  int unsigned           cycles = 0;
  trace_pkg::perf_addr_t next_addr = '0;
  logic                  check_done = 1'b0;
  logic                  summary_done = 1'b0;
  logic                  timeout = 1'b0;

  assign check_done_o   = check_done;
  assign summary_done_o = summary_done;
  assign timeout_o      = timeout;
  assign errors_o       = n_errors;

  initial begin
    perf_addr_o = '0;
  end

  task automatic compare(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
    n_checks++;
    if (expected !== actual) begin
      n_errors++;
      $display("CHECK FAILED %s %s: expected 0x%0h actual 0x%0h",
               test_name_i, what, expected, actual);
    end
  endtask

  task automatic report_problem(input string msg);
    n_errors++;
    $display("test %s: %s", test_name_i, msg);
  endtask

  task automatic reset_model();
    for (int unsigned p = 0; p < NrCommitPorts; p++) begin
      ref_fill[p] = 0;
    end
    for (int unsigned k = 0; k < 4; k++) begin
      ref_cnt[k] = '0;
    end
    credits      = TraceCredits;
    rr           = 0;
    exp_valid    = 1'b0;
    items_seen   = 0;
    credits_seen = 0;
  endtask

  // ----------------------------------------
  // trace stream and credit bound
  // ----------------------------------------
  task automatic check_trace();
    if (trace_valid_i) begin
      items_seen++;
      if (items_seen > TraceCredits + credits_seen) begin
        report_problem("trace item sent without a credit");
      end
    end
    if (trace_credit_i) begin
      credits_seen++;
    end
    compare("trace valid", 64'(exp_valid), 64'(trace_valid_i));
    if (exp_valid && trace_valid_i) begin
      compare("trace pc", exp_pc, trace_pc_i);
      compare("trace port", 64'(exp_port), 64'(trace_port_i));
    end
  endtask

  // one clock of queues, arbiter and counters
  task automatic step_model();
    int unsigned p;
    exp_valid = 1'b0;
    if (credits != 0) begin
      for (int unsigned off = 0; off < NrCommitPorts; off++) begin
        p = (rr + off) % NrCommitPorts;
        if (!exp_valid && ref_fill[p] != 0) begin
          exp_valid = 1'b1;
          exp_port  = p;
        end
      end
    end
    if (exp_valid) begin
      exp_pc = ref_mem[exp_port][0];
      for (int unsigned k = 0; k + 1 < QueueDepth; k++) begin
        ref_mem[exp_port][k] = ref_mem[exp_port][k+1];
      end
      ref_fill[exp_port]--;
      rr = (exp_port + 1) % NrCommitPorts;
      credits--;
    end
    if (trace_credit_i) begin
      credits++;
    end
    for (int unsigned q = 0; q < NrCommitPorts; q++) begin
      if (commit_ack_i[q] && !commit_ex_valid_i[q]) begin
        ref_cnt[trace_pkg::PerfInstret]++;
        // the pop above already freed a slot
        if (ref_fill[q] < QueueDepth) begin
          ref_mem[q][ref_fill[q]] = commit_pc_i[q];
          ref_fill[q]++;
        end else begin
          ref_cnt[trace_pkg::PerfDropped]++;
        end
      end else if (commit_ack_i[q] && commit_cause_i[q][trace_pkg::CauseIrqBit]) begin
        ref_cnt[trace_pkg::PerfInterrupt]++;
      end else if (commit_ack_i[q]) begin
        ref_cnt[trace_pkg::PerfException]++;
      end
    end
  endtask

  // ----------------------------------------
  // end of test
  // ----------------------------------------
  task automatic read_counter();
    compare($sformatf("counter %0d", perf_addr_o), ref_cnt[perf_addr_o], perf_data_i);
    next_addr = perf_addr_o + 1'b1;
    reads_done++;
    if (reads_done == 4) begin
      for (int unsigned p = 0; p < NrCommitPorts; p++) begin
        if (ref_fill[p] != 0) begin
          report_problem($sformatf("port %0d still holds %0d pcs", p, ref_fill[p]));
        end
      end
      n_tests++;
      if (n_errors == test_err_base) begin
        $display("test %s: pass", test_name_i);
      end else begin
        $display("test %s: %0d errors", test_name_i, n_errors - test_err_base);
      end
      test_err_base = n_errors;
      check_done    = 1'b1;
    end
  endtask

  // counters are compared before this cycle's events are added
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      reset_model();
    end else begin
      check_trace();
      if (check_req_i && !check_done) begin
        read_counter();
      end else if (!check_req_i) begin
        check_done = 1'b0;
        reads_done = 0;
      end
      step_model();
      if (run_done_i && !summary_done) begin
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        summary_done = 1'b1;
      end
    end
  end

  always @(posedge clk_i) begin
    perf_addr_o <= next_addr;
    cycles++;
    if (cycles > cycle_limit_i && !timeout) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit_i);
      timeout = 1'b1;
    end
  end

endmodule

// ==== tests/tb_top.sv ====
// commit trace testbench

`timescale 1ns/1ps

module tb_top;

  localparam int unsigned NrCommitPorts = 2;
  localparam int unsigned QueueDepth    = 4;
  localparam int unsigned TraceCredits  = 2;
  localparam int unsigned NrSteps       = 14;
  localparam int unsigned PortIdxWidth  = (NrCommitPorts > 1) ? $clog2(NrCommitPorts) : 1;

  typedef struct {
    string             name;
    logic [1:0]        ack;
    logic [1:0]        ex_valid;
    trace_pkg::pc_t    pc0;
    trace_pkg::pc_t    pc1;
    trace_pkg::cause_t cause0;
    trace_pkg::cause_t cause1;
    logic              credit_en;
    int unsigned       hold;
    logic              last;
  } step_t;

  step_t                                 steps [NrSteps];
  logic                                  clk;
  logic                                  rst_n;
  logic [NrCommitPorts-1:0]              commit_ack;
  trace_pkg::pc_t [NrCommitPorts-1:0]    commit_pc;
  logic [NrCommitPorts-1:0]              commit_ex_valid;
  trace_pkg::cause_t [NrCommitPorts-1:0] commit_cause;
  logic                                  trace_valid;
  trace_pkg::pc_t                        trace_pc;
  logic [PortIdxWidth-1:0]               trace_port;
  logic                                  trace_credit;
  trace_pkg::perf_addr_t                 perf_addr;
  trace_pkg::counter_t                   perf_data;
  string                                 test_name;
  logic                                  credit_en;
  logic                                  check_req;
  logic                                  check_done;
  logic                                  run_done;
  logic                                  summary_done;
  logic                                  timed_out;
  int unsigned                           errors;
  int unsigned                           cycle_limit;
  int unsigned                           items_rx = 0;
  int unsigned                           credits_tx = 0;
  int unsigned                           credit_wait = 2;
  integer                                seed = 32'ha569_2de5;

  commit_trace_top #(
    .NrCommitPorts ( NrCommitPorts ),
    .QueueDepth    ( QueueDepth    ),
    .TraceCredits  ( TraceCredits  )
  ) dut0 (
    .clk_i             ( clk             ),
    .rst_ni            ( rst_n           ),
    .commit_ack_i      ( commit_ack      ),
    .commit_pc_i       ( commit_pc       ),
    .commit_ex_valid_i ( commit_ex_valid ),
    .commit_cause_i    ( commit_cause    ),
    .trace_valid_o     ( trace_valid     ),
    .trace_pc_o        ( trace_pc        ),
    .trace_port_o      ( trace_port      ),
    .trace_credit_i    ( trace_credit    ),
    .perf_addr_i       ( perf_addr       ),
    .perf_data_o       ( perf_data       )
  );

  tb_checker #(
    .NrCommitPorts ( NrCommitPorts ),
    .QueueDepth    ( QueueDepth    ),
    .TraceCredits  ( TraceCredits  )
  ) chk0 (
    .clk_i (clk), .rst_ni (rst_n),
    .commit_ack_i (commit_ack), .commit_pc_i (commit_pc),
    .commit_ex_valid_i (commit_ex_valid), .commit_cause_i (commit_cause),
    .trace_valid_i (trace_valid), .trace_pc_i (trace_pc), .trace_port_i (trace_port),
    .trace_credit_i (trace_credit), .perf_addr_o (perf_addr), .perf_data_i (perf_data),
    .test_name_i (test_name), .check_req_i (check_req), .check_done_o (check_done),
    .run_done_i (run_done), .summary_done_o (summary_done),
    .cycle_limit_i (cycle_limit), .timeout_o (timed_out), .errors_o (errors)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------
  // stimulus table
  // ----------------------------------------
  // name, ack, ex_valid, pc0, pc1, cause0, cause1, credits on, hold, last
  task automatic load_steps();
    steps[0]  = '{"reset_state", 2'b00, 2'b00, 64'h0, 64'h0, 64'h0, 64'h0, 1'b1, 2, 1'b1};
    steps[1]  = '{"port_order", 2'b01, 2'b00, 64'h1000, 64'h0, 64'h0, 64'h0, 1'b1, 3, 1'b0};
    steps[2]  = '{"port_order", 2'b00, 2'b00, 64'h0, 64'h0, 64'h0, 64'h0, 1'b1, 2, 1'b0};
    steps[3]  = '{"port_order", 2'b10, 2'b00, 64'h0, 64'h2000, 64'h0, 64'h0, 1'b1, 3, 1'b0};
    steps[4]  = '{"port_order", 2'b11, 2'b00, 64'h1100, 64'h2100, 64'h0, 64'h0, 1'b1, 1, 1'b0};
    steps[5]  = '{"port_order", 2'b00, 2'b00, 64'h0, 64'h0, 64'h0, 64'h0, 1'b1, 15, 1'b1};
    steps[6]  = '{"balanced", 2'b11, 2'b00, 64'h3000, 64'h4000, 64'h0, 64'h0, 1'b1, 6, 1'b0};
    steps[7]  = '{"balanced", 2'b00, 2'b00, 64'h0, 64'h0, 64'h0, 64'h0, 1'b1, 30, 1'b1};
    // interrupt cause has the top bit set
    steps[8]  = '{"classify", 2'b11, 2'b11, 64'h5000, 64'h5100,
                  64'h8000_0000_0000_0007, 64'h2, 1'b1, 2, 1'b0};
    steps[9]  = '{"classify", 2'b11, 2'b10, 64'h5200, 64'h5300,
                  64'h0, 64'h8000_0000_0000_000b, 1'b1, 2, 1'b0};
    steps[10] = '{"classify", 2'b00, 2'b00, 64'h0, 64'h0, 64'h0, 64'h0, 1'b1, 12, 1'b1};
    steps[11] = '{"backpressure", 2'b11, 2'b00, 64'h6000, 64'h7000, 64'h0, 64'h0, 1'b0, 8, 1'b0};
    steps[12] = '{"backpressure", 2'b00, 2'b00, 64'h0, 64'h0, 64'h0, 64'h0, 1'b0, 4, 1'b0};
    steps[13] = '{"backpressure", 2'b00, 2'b00, 64'h0, 64'h0, 64'h0, 64'h0, 1'b1, 30, 1'b1};
  endtask

  // counter read handshake with the checker
  task automatic run_check();
    @(posedge clk);
    check_req <= 1'b1;
    while (!check_done) begin
      @(posedge clk);
    end
    check_req <= 1'b0;
  endtask

  // credit return a few cycles after each item
  always @(negedge clk) begin
    if (trace_valid) begin
      items_rx++;
    end
  end

  always @(posedge clk) begin
    trace_credit <= 1'b0;
    if (credit_en && items_rx > credits_tx) begin
      if (credit_wait == 0) begin
        trace_credit <= 1'b1;
        credits_tx++;
        credit_wait = 1 + ($unsigned($random(seed)) % 3);
      end else begin
        credit_wait--;
      end
    end
  end

  initial begin
    wait (timed_out);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int unsigned total;
    rst_n           = 1'b0;
    commit_ack      = '0;
    commit_pc       = '0;
    commit_ex_valid = '0;
    commit_cause    = '0;
    trace_credit    = 1'b0;
    test_name       = "reset";
    credit_en       = 1'b1;
    check_req       = 1'b0;
    run_done        = 1'b0;
    load_steps();
    total = 0;
    for (int unsigned s = 0; s < NrSteps; s++) begin
      total += steps[s].hold + (steps[s].last ? 8 : 0);
    end
    cycle_limit = total + 100;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    for (int unsigned s = 0; s < NrSteps; s++) begin
      for (int unsigned c = 0; c < steps[s].hold; c++) begin
        @(posedge clk);
        test_name       <= steps[s].name;
        credit_en       <= steps[s].credit_en;
        commit_ack      <= steps[s].ack;
        commit_ex_valid <= steps[s].ex_valid;
        commit_pc       <= {steps[s].pc1 + 64'(4 * c), steps[s].pc0 + 64'(4 * c)};
        commit_cause    <= {steps[s].cause1, steps[s].cause0};
      end
      if (steps[s].last) begin
        run_check();
      end
    end
    @(posedge clk);
    run_done <= 1'b1;
    while (!summary_done) begin
      @(posedge clk);
    end
    if (errors == 0 && !timed_out) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== commit_trace.f ====
design/trace_pkg.sv
design/commit_if.sv
design/pc_queue_bank.sv
design/trace_arbiter.sv
design/perf_counters.sv
design/commit_trace_top.sv
tests/tb_checker.sv
tests/tb_top.sv
